//--- mcpu_pkg.sv
`default_nettype none

package mcpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [2:0] {
        PH_IF  = 3'd0,
        PH_ID  = 3'd1,
        PH_EXE = 3'd2,
        PH_MEM = 3'd3,
        PH_WB  = 3'd4
    } mcpu_phase_e;

    typedef enum logic [4:0] {
        OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
        OP_NOR, OP_AND, OP_OR, OP_XOR,
        OP_SLLI_W, OP_SRLI_W, OP_SRAI_W,
        OP_ADDI_W, OP_LU12I_W,
        OP_LD_W, OP_ST_W,
        OP_JIRL, OP_B, OP_BL, OP_BEQ, OP_BNE,
        OP_INVALID
    } mcpu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI              // Passes src2
    } alu_op_e;

endpackage

`default_nettype wire

//--- exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_if import mcpu_pkg::*; ();

    mcpu_op_e           op;
    alu_op_e            alu_op;
    logic [XLEN-1:0]    src1;
    logic [XLEN-1:0]    src2;
    logic [XLEN-1:0]    store_data;
    logic [REG_AW-1:0]  dest;
    logic               gr_we;
    logic [XLEN-1:0]    alu_result;

    modport dec (output op, alu_op, src1, src2, store_data, dest, gr_we);

    modport alu (input alu_op, src1, src2, output alu_result);

    modport wb  (input op, store_data, dest, gr_we, alu_result);

endinterface

`default_nettype wire

//--- mcpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_sequencer import mcpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  mcpu_op_e        op,
    input  logic            br_taken,
    input  logic [XLEN-1:0] br_target,
    output mcpu_phase_e     phase,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] inst,
    output logic [XLEN-1:0] inst_sram_addr,
    input  logic [XLEN-1:0] inst_sram_rdata
);

    mcpu_phase_e     next_phase;
    logic [XLEN-1:0] fetch_pc;              // Address of the next fetch

    always_comb begin
        case (phase)
            PH_IF:   next_phase = PH_ID;
            PH_ID:   next_phase = (op inside {OP_B, OP_BEQ, OP_BNE, OP_INVALID}) ? PH_IF : PH_EXE;
            PH_EXE:  next_phase = (op inside {OP_LD_W, OP_ST_W}) ? PH_MEM : PH_WB;
            PH_MEM:  next_phase = (op == OP_LD_W) ? PH_WB : PH_IF;
            default: next_phase = PH_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= PH_IF;
            fetch_pc <= RESET_PC;
            pc       <= RESET_PC;
        end else begin
            phase <= next_phase;
            if (phase == PH_IF)
                pc <= fetch_pc;             // pc of the instruction in flight
            if (phase == PH_ID)
                fetch_pc <= br_taken ? br_target : fetch_pc + XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IF)
            inst <= inst_sram_rdata;
    end

    assign inst_sram_addr = fetch_pc;

    a_phase_legal: assert property (@(posedge clk) disable iff (reset)
        phase inside {PH_IF, PH_ID, PH_EXE, PH_MEM, PH_WB});

    // Redirects from the decoder must keep fetches word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        fetch_pc[1:0] == 2'b00);

    a_br_in_id: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> phase == PH_ID);

endmodule

`default_nettype wire

//--- mcpu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_decoder import mcpu_pkg::*; (
    input  mcpu_phase_e       phase,
    input  logic [XLEN-1:0]   inst,
    input  logic [XLEN-1:0]   pc,
    output logic [REG_AW-1:0] rf_raddr1,
    output logic [REG_AW-1:0] rf_raddr2,
    input  logic [XLEN-1:0]   rf_rdata1,
    input  logic [XLEN-1:0]   rf_rdata2,
    output mcpu_op_e          op,
    output logic              br_taken,
    output logic [XLEN-1:0]   br_target,
    exec_if.dec               ex
);

    logic [REG_AW-1:0] rd, rj, rk;
    logic [XLEN-1:0]   si12, ui5, si16, si20, si26;
    logic              rj_eq_rd;
    logic              cond_met;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign ui5  = {27'b0, inst[14:10]};
    assign si16 = {{14{inst[25]}}, inst[25:10], 2'b00};          // Branch offset in bytes
    assign si20 = {inst[24:5], 12'b0};
    assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        op = OP_INVALID;
        case (inst[31:26])
            6'h00: begin
                if (inst[25:20] == 6'b0000_01) begin
                    case (inst[19:15])
                        5'h00: op = OP_ADD_W;
                        5'h02: op = OP_SUB_W;
                        5'h04: op = OP_SLT;
                        5'h05: op = OP_SLTU;
                        5'h08: op = OP_NOR;
                        5'h09: op = OP_AND;
                        5'h0a: op = OP_OR;
                        5'h0b: op = OP_XOR;
                        default: op = OP_INVALID;
                    endcase
                end else if (inst[25:20] == 6'b0001_00) begin
                    case (inst[19:15])
                        5'h01: op = OP_SLLI_W;
                        5'h09: op = OP_SRLI_W;
                        5'h11: op = OP_SRAI_W;
                        default: op = OP_INVALID;
                    endcase
                end else if (inst[25:22] == 4'ha) begin
                    op = OP_ADDI_W;
                end
            end
            6'h05: if (!inst[25]) op = OP_LU12I_W;
            6'h0a: begin
                if (inst[25:22] == 4'h2)
                    op = OP_LD_W;
                else if (inst[25:22] == 4'h6)
                    op = OP_ST_W;
            end
            6'h13: op = OP_JIRL;
            6'h14: op = OP_B;
            6'h15: op = OP_BL;
            6'h16: op = OP_BEQ;
            6'h17: op = OP_BNE;
            default: op = OP_INVALID;
        endcase
    end

    always_comb begin
        case (op)
            OP_SUB_W:   ex.alu_op = ALU_SUB;
            OP_SLT:     ex.alu_op = ALU_SLT;
            OP_SLTU:    ex.alu_op = ALU_SLTU;
            OP_NOR:     ex.alu_op = ALU_NOR;
            OP_AND:     ex.alu_op = ALU_AND;
            OP_OR:      ex.alu_op = ALU_OR;
            OP_XOR:     ex.alu_op = ALU_XOR;
            OP_SLLI_W:  ex.alu_op = ALU_SLL;
            OP_SRLI_W:  ex.alu_op = ALU_SRL;
            OP_SRAI_W:  ex.alu_op = ALU_SRA;
            OP_LU12I_W: ex.alu_op = ALU_LUI;
            default:    ex.alu_op = ALU_ADD;    // Also address and link sums
        endcase
    end

    always_comb begin
        case (op)
            OP_SLLI_W, OP_SRLI_W, OP_SRAI_W: ex.src2 = ui5;
            OP_ADDI_W, OP_LD_W, OP_ST_W:     ex.src2 = si12;
            OP_LU12I_W:                      ex.src2 = si20;
            OP_B, OP_BL, OP_JIRL:            ex.src2 = XLEN'(4);
            default:                         ex.src2 = rf_rdata2;
        endcase
    end

    assign rf_raddr1 = rj;
    assign rf_raddr2 = (op inside {OP_BEQ, OP_BNE, OP_ST_W}) ? rd : rk;

    assign ex.op         = op;
    assign ex.src1       = (op inside {OP_B, OP_BL, OP_JIRL}) ? pc : rf_rdata1;
    assign ex.store_data = rf_rdata2;
    assign ex.dest       = (op == OP_BL) ? REG_AW'(1) : rd;
    assign ex.gr_we      = !(op inside {OP_ST_W, OP_BEQ, OP_BNE, OP_B, OP_INVALID});

    assign rj_eq_rd = (rf_rdata1 == rf_rdata2);
    assign cond_met = (op == OP_BEQ &&  rj_eq_rd) ||
                      (op == OP_BNE && !rj_eq_rd) ||
                      (op inside {OP_B, OP_BL, OP_JIRL});

    assign br_taken  = (phase == PH_ID) && cond_met;
    assign br_target = (op == OP_JIRL) ? rf_rdata1 + si16 :
                       pc + ((op inside {OP_B, OP_BL}) ? si26 : si16);

endmodule

`default_nettype wire

//--- mcpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_regfile import mcpu_pkg::*; (
    input  logic              clk,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    input  logic              we,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];     // r0 reads as zero
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- mcpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_alu import mcpu_pkg::*; (
    exec_if.alu ex
);

    logic [4:0] shamt;

    assign shamt = ex.src2[4:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:  ex.alu_result = ex.src1 + ex.src2;
            ALU_SUB:  ex.alu_result = ex.src1 - ex.src2;
            ALU_SLT:  ex.alu_result = {{(XLEN-1){1'b0}}, $signed(ex.src1) < $signed(ex.src2)};
            ALU_SLTU: ex.alu_result = {{(XLEN-1){1'b0}}, ex.src1 < ex.src2};
            ALU_AND:  ex.alu_result = ex.src1 & ex.src2;
            ALU_NOR:  ex.alu_result = ~(ex.src1 | ex.src2);
            ALU_OR:   ex.alu_result = ex.src1 | ex.src2;
            ALU_XOR:  ex.alu_result = ex.src1 ^ ex.src2;
            ALU_SLL:  ex.alu_result = ex.src1 << shamt;
            ALU_SRL:  ex.alu_result = ex.src1 >> shamt;
            ALU_SRA:  ex.alu_result = $unsigned($signed(ex.src1) >>> shamt);
            ALU_LUI:  ex.alu_result = ex.src2;
            default:  ex.alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- mcpu_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_mem_wb import mcpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  mcpu_phase_e       phase,
    input  logic [XLEN-1:0]   pc,
    exec_if.wb                ex,
    output logic              data_sram_we,
    output logic [XLEN-1:0]   data_sram_addr,
    output logic [XLEN-1:0]   data_sram_wdata,
    input  logic [XLEN-1:0]   data_sram_rdata,
    output logic              rf_we,
    output logic [REG_AW-1:0] rf_waddr,
    output logic [XLEN-1:0]   rf_wdata,
    output logic [XLEN-1:0]   debug_wb_pc,
    output logic              debug_wb_rf_we,
    output logic [REG_AW-1:0] debug_wb_rf_wnum,
    output logic [XLEN-1:0]   debug_wb_rf_wdata
);

    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] final_result;
    logic            wb_next;                // WB follows this cycle

    assign wb_next = (phase == PH_EXE && !(ex.op inside {OP_LD_W, OP_ST_W})) ||
                     (phase == PH_MEM && ex.op == OP_LD_W);

    always_ff @(posedge clk) begin
        if (reset) begin
            data_sram_we <= 1'b0;
            rf_we        <= 1'b0;
        end else begin
            data_sram_we <= (phase == PH_EXE) && (ex.op == OP_ST_W);
            rf_we        <= wb_next && ex.gr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_MEM && ex.op == OP_LD_W)
            load_data <= data_sram_rdata;
    end

    assign data_sram_addr  = ex.alu_result;
    assign data_sram_wdata = ex.store_data;

    assign final_result = (ex.op == OP_LD_W) ? load_data : ex.alu_result;
    assign rf_waddr     = ex.dest;
    assign rf_wdata     = final_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = ex.dest;
    assign debug_wb_rf_wdata = final_result;

    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> phase == PH_MEM);

endmodule

`default_nettype wire

//--- mcpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_top import mcpu_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [ 4:0] debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    mcpu_phase_e       phase;
    mcpu_op_e          op;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   inst;
    logic              br_taken;
    logic [XLEN-1:0]   br_target;
    logic [REG_AW-1:0] rf_raddr1, rf_raddr2;
    logic [XLEN-1:0]   rf_rdata1, rf_rdata2;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    exec_if ex ();

    mcpu_sequencer #(.RESET_PC(RESET_PC)) u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .op              (op),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .phase           (phase),
        .pc              (pc),
        .inst            (inst),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata)
    );

    mcpu_decoder u_decoder (
        .phase     (phase),
        .inst      (inst),
        .pc        (pc),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .op        (op),
        .br_taken  (br_taken),
        .br_target (br_target),
        .ex        (ex.dec)
    );

    mcpu_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    mcpu_alu u_alu (
        .ex (ex.alu)
    );

    mcpu_mem_wb u_mem_wb (
        .clk               (clk),
        .reset             (reset),
        .phase             (phase),
        .pc                (pc),
        .ex                (ex.wb),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- mcpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_tb;

    localparam logic [31:0] RESET_PC     = 32'h1c00_0000;
    localparam logic [31:0] DATA_BASE    = 32'h1c80_0000;   // 4 KB data window
    localparam int          N_INSTR      = 2000;
    localparam int          RESET_CYCLES = 8;
    localparam int          TIMEOUT_NS   = (N_INSTR * 5 + RESET_CYCLES + 50) * 8;

    localparam int K_ADD = 0, K_SUB = 1, K_SLT = 2, K_SLTU = 3, K_NOR = 4, K_AND = 5;
    localparam int K_OR = 6, K_XOR = 7, K_SLLI = 8, K_SRLI = 9, K_SRAI = 10, K_ADDI = 11;
    localparam int K_LU12I = 12, K_LD = 13, K_ST = 14, K_JIRL = 15, K_B = 16, K_BL = 17;
    localparam int K_BEQ = 18, K_BNE = 19;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr, inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [logic [31:0]];
    int          ikind [logic [31:0]];
    logic [31:0] dmem [logic [31:0]];
    logic [31:0] mregs [32];
    logic [31:0] mpc;
    logic [31:0] lfsr_state;
    int          init_count;
    int          errors;

    logic        exp_we, exp_store;
    logic [4:0]  exp_wnum;
    logic [31:0] exp_wdata, exp_saddr, exp_sdata, exp_next;
    int          exp_cycles;

    tb_clock #(.PERIOD_NS(8)) u_clock (.clk(clk));

    mcpu_top #(.RESET_PC(RESET_PC)) uut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'h8020_0003;   // Galois taps
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [4:0] f5, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {6'h00, 6'h01, f5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shift(input logic [4:0] f5, input logic [4:0] ui5,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {6'h00, 6'h04, f5, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [9:0] opc, input logic [11:0] imm,
                                            input logic [4:0] rj, input logic [4:0] rd);
        return {opc, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i16(input logic [5:0] opc, input logic [15:0] offs,
                                            input logic [4:0] rj, input logic [4:0] rd);
        return {opc, offs, rj, rd};
    endfunction

    function automatic logic [4:0] funct_of(input int k);
        case (k)
            K_ADD:   return 5'h00;
            K_SUB:   return 5'h02;
            K_SLT:   return 5'h04;
            K_SLTU:  return 5'h05;
            K_NOR:   return 5'h08;
            K_AND:   return 5'h09;
            K_OR:    return 5'h0a;
            K_XOR:   return 5'h0b;
            K_SLLI:  return 5'h01;
            K_SRLI:  return 5'h09;
            default: return 5'h11;
        endcase
    endfunction

    function automatic bit is_free(input logic [31:0] addr);
        return !imem.exists(addr);
    endfunction

    task automatic put_word(input logic [31:0] addr, input int k, input logic [31:0] word);
        imem[addr]  = word;
        ikind[addr] = k;
    endtask

    task automatic generate_at(input logic [31:0] addr);
        int          k;
        logic [31:0] r1, r2, r3, r4, r5;
        logic [15:0] offs;
        logic [25:0] offl;
        r1 = rand_bits(5);
        r2 = rand_bits(5);
        r3 = rand_bits(5);
        r4 = rand_bits(12);
        r5 = rand_bits(8);
        k  = int'(rand_bits(5) % 32'd20);
        offs = {12'b0, r4[3:0]} + 16'd1;                  // Forward only, no endless loops
        offl = {22'b0, r4[3:0]} + 26'd1;
        if (init_count < 31) begin
            init_count++;                                   // Seed r1..r31 first
            put_word(addr, K_ADDI, enc_i12(10'h00a, r4[11:0], 5'd0, 5'(init_count)));
        end else if ((k == K_LD || k == K_ST) && is_free(addr + 4) && is_free(addr + 8)) begin
            put_word(addr, K_LU12I, {7'b0001010, DATA_BASE[31:12], 5'd30});
            put_word(addr + 4, K_ADDI,
                     enc_i12(10'h00a, {2'b00, r5[7:0], 2'b00}, 5'd30, 5'd30));
            put_word(addr + 8, k, enc_i12((k == K_LD) ? 10'h0a2 : 10'h0a6,
                                          {2'b00, r4[7:0], 2'b00}, 5'd30, r1[4:0]));
        end else if (k == K_JIRL && is_free(addr + 4)) begin
            put_word(addr, K_LU12I, {7'b0001010, addr[31:12], 5'd29});
            offs = {6'b0, addr[11:2]} + 16'd2 + {12'b0, r4[3:0]};
            put_word(addr + 4, K_JIRL, enc_i16(6'h13, offs, 5'd29, r1[4:0]));
        end else begin
            case (k)
                K_ADD, K_SUB, K_SLT, K_SLTU, K_NOR, K_AND, K_OR, K_XOR:
                    put_word(addr, k, enc_3r(funct_of(k), r3[4:0], r2[4:0], r1[4:0]));
                K_SLLI, K_SRLI, K_SRAI:
                    put_word(addr, k, enc_shift(funct_of(k), r3[4:0], r2[4:0], r1[4:0]));
                K_LU12I:
                    put_word(addr, k, {7'b0001010, r4[11:0], r3[4:0], r2[2:0], r1[4:0]});
                K_B:     put_word(addr, k, {6'h14, offl[15:0], offl[25:16]});
                K_BL:    put_word(addr, k, {6'h15, offl[15:0], offl[25:16]});
                K_BEQ:   put_word(addr, k, enc_i16(6'h16, offs, r2[4:0], r1[4:0]));
                K_BNE:   put_word(addr, k, enc_i16(6'h17, offs, r2[4:0], r1[4:0]));
                default: put_word(addr, K_ADDI, enc_i12(10'h00a, r4[11:0], r2[4:0], r1[4:0]));
            endcase
        end
    endtask

    // Instruction-set model of one instruction at addr
    task automatic model_step(input logic [31:0] addr);
        logic [31:0] w, a, b, d, si12, off16, off26;
        int          k;
        w = imem[addr];
        k = ikind[addr];
        a = mregs[w[9:5]];
        b = mregs[w[14:10]];
        d = mregs[w[4:0]];
        si12  = {{20{w[21]}}, w[21:10]};
        off16 = {{14{w[25]}}, w[25:10], 2'b00};
        off26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        exp_we     = 1'b1;
        exp_store  = 1'b0;
        exp_wnum   = w[4:0];
        exp_cycles = 4;
        exp_next   = addr + 4;
        exp_wdata  = '0;
        exp_saddr  = a + si12;
        exp_sdata  = d;
        case (k)
            K_ADD:   exp_wdata = a + b;
            K_SUB:   exp_wdata = a - b;
            K_SLT:   exp_wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLTU:  exp_wdata = (a < b) ? 32'd1 : 32'd0;
            K_NOR:   exp_wdata = ~(a | b);
            K_AND:   exp_wdata = a & b;
            K_OR:    exp_wdata = a | b;
            K_XOR:   exp_wdata = a ^ b;
            K_SLLI:  exp_wdata = a << w[14:10];
            K_SRLI:  exp_wdata = a >> w[14:10];
            K_SRAI:  exp_wdata = $unsigned($signed(a) >>> w[14:10]);
            K_ADDI:  exp_wdata = a + si12;
            K_LU12I: exp_wdata = {w[24:5], 12'b0};
            K_LD: begin
                exp_cycles = 5;
                exp_wdata  = dmem.exists(exp_saddr) ? dmem[exp_saddr] : 32'd0;
            end
            K_ST: begin
                exp_we    = 1'b0;
                exp_store = 1'b1;
            end
            K_JIRL: begin
                exp_wdata = addr + 4;
                exp_next  = a + off16;
            end
            K_BL: begin
                exp_wdata = addr + 4;
                exp_wnum  = 5'd1;
                exp_next  = addr + off26;
            end
            K_B: begin
                exp_we     = 1'b0;
                exp_cycles = 2;
                exp_next   = addr + off26;
            end
            default: begin                                  // beq and bne
                exp_we     = 1'b0;
                exp_cycles = 2;
                if ((a == d) == (k == K_BEQ))
                    exp_next = addr + off16;
            end
        endcase
        if (exp_we && exp_wnum != 5'd0)
            mregs[exp_wnum] = exp_wdata;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic serve_memories;
        inst_sram_rdata = imem.exists(inst_sram_addr) ? imem[inst_sram_addr] : 32'd0;
        data_sram_rdata = dmem.exists(data_sram_addr) ? dmem[data_sram_addr] : 32'd0;
    endtask

    // Called 1 ns into the fetch cycle, returns 1 ns into the next fetch
    task automatic retire_one;
        bit wb_now, st_now;
        check_value("inst_sram_addr", inst_sram_addr, mpc);
        if (is_free(mpc))
            generate_at(mpc);
        model_step(mpc);
        for (int c = 0; c < exp_cycles; c++) begin
            if (c > 0) begin
                @(posedge clk);
                #1;
            end
            serve_memories();
            st_now = exp_store && c == 3;
            wb_now = exp_we && c == exp_cycles - 1;
            check_value("data_sram_we", 32'(data_sram_we), 32'(st_now));
            check_value("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'(wb_now));
            if (st_now) begin
                check_value("data_sram_addr", data_sram_addr, exp_saddr);
                check_value("data_sram_wdata", data_sram_wdata, exp_sdata);
                dmem[exp_saddr] = exp_sdata;
            end
            if (wb_now) begin
                check_value("debug_wb_pc", debug_wb_pc, mpc);
                check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(exp_wnum));
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata);
            end
        end
        mpc = exp_next;
        @(posedge clk);
        #1;
    endtask

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        lfsr_state      = 32'd29495;
        init_count      = 0;
        errors          = 0;
        mpc             = RESET_PC;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("data_sram_we", 32'(data_sram_we), 32'd0);
            check_value("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'd0);
            check_value("inst_sram_addr", inst_sram_addr, RESET_PC);
        end
        reset = 1'b0;                                       // This cycle is the first IF
        for (int n = 0; n < N_INSTR; n++)
            retire_one();
        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "%0d checks failed", errors);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before %0d instructions retired", N_INSTR);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- flist.f
mcpu_pkg.sv
exec_if.sv
mcpu_sequencer.sv
mcpu_decoder.sv
mcpu_regfile.sv
mcpu_alu.sv
mcpu_mem_wb.sv
mcpu_top.sv
tb_clock.sv
mcpu_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f flist.f --top-module mcpu_tb -o mcpu_sim
	@out=$$(./obj_dir/mcpu_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir
